// File: logic/monitor_pkg.sv
/*
 * Shared sizes, message field positions and types for the PDES core monitor.
 * Modules import it inside their bodies; port lists use scoped names.
 */
package monitor_pkg;

   // core and LP counts
   localparam int num_core = 4;
   localparam int core_id_w = $clog2(num_core);
   localparam int num_lp = 8;
   localparam int lp_id_w = $clog2(num_lp);

   // message layout
   localparam int time_w = 16;
   localparam int msg_w = 32;
   localparam int time_lsb = 0;
   localparam int lp_lsb = 16;
   // set on a return when the core has finished its event
   localparam int end_bit = 31;

   // one register per level of the min-select tree
   localparam int tree_levels = core_id_w;
   // input reg, match reg, tree, stall reg
   localparam int release_latency = 3 + tree_levels;

   typedef logic [core_id_w-1:0] core_id_t;
   typedef logic [lp_id_w-1:0]   lp_id_t;
   typedef logic [time_w-1:0]    time_t;
   typedef logic [msg_w-1:0]     msg_t;
   // one bit per core
   typedef logic [num_core-1:0]  core_mask_t;

   // event tag carried down the pipeline
   typedef enum logic [1:0] {
      op_none = 2'd0,
      op_send = 2'd1,
      op_recv = 2'd2
   } op_kind_t;

endpackage

// File: logic/core_table.sv
/*
 * Per-core LP/timestamp table with the first two pipeline stages.
 * Stage one registers the event tag, stage two registers the match vector
 * and a snapshot of the table timestamps for the min-select tree.
 */
`timescale 1ns/1ps

module core_table (
   input  logic                    clk,
   input  logic                    reset,
   input  monitor_pkg::msg_t       msg,
   input  logic                    sent_vld,
   input  logic                    rcv_vld,
   input  monitor_pkg::core_id_t   core_id,
   input  monitor_pkg::core_mask_t active,
   output monitor_pkg::op_kind_t   stage_op,
   output monitor_pkg::core_id_t   stage_core,
   output monitor_pkg::core_mask_t match,
   output monitor_pkg::time_t      entry_time [monitor_pkg::num_core]
);
   import monitor_pkg::*;

   lp_id_t     msg_lp;
   time_t      msg_time;
   logic       msg_end;

   // table contents
   lp_id_t     tab_lp   [num_core];
   time_t      tab_time [num_core];

   // input register stage
   op_kind_t   in_op;
   core_id_t   in_core;
   lp_id_t     in_lp;
   core_mask_t in_active;

   lp_id_t     origin_lp;
   core_mask_t match_next;

   // message field decode
   assign msg_lp = msg[lp_lsb +: lp_id_w];
   assign msg_time = msg[time_lsb +: time_w];
   assign msg_end = msg[end_bit];

   // a send overwrites the destination entry
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int c = 0; c < num_core; c++) begin
            tab_lp[c] <= '0;
            tab_time[c] <= '0;
         end
      end else if (sent_vld) begin
         tab_lp[core_id] <= msg_lp;
         tab_time[core_id] <= msg_time;
      end
   end

   // event tag, returns count only with end bit set
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         in_op <= op_none;
         in_active <= '0;
      end else begin
         if (sent_vld)
            in_op <= op_send;
         else if (rcv_vld && msg_end)
            in_op <= op_recv;
         else
            in_op <= op_none;
         in_active <= active;
      end
   end

   always_ff @(posedge clk) begin
      in_core <= core_id;
      in_lp <= msg_lp;
   end

   // send compares the new LP, return compares the origin's table LP
   assign origin_lp = (in_op == op_send) ? in_lp : tab_lp[in_core];

   always_comb begin
      for (int c = 0; c < num_core; c++) begin
         match_next[c] = in_active[c] && (tab_lp[c] == origin_lp)
                         && (core_id_t'(c) != in_core);
      end
   end

   // match stage, tag kept aligned with its vector
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stage_op <= op_none;
         match <= '0;
      end else begin
         stage_op <= in_op;
         match <= match_next;
      end
   end

   // timestamps frozen for this event
   always_ff @(posedge clk) begin
      stage_core <= in_core;
      for (int c = 0; c < num_core; c++)
         entry_time[c] <= tab_time[c];
   end

endmodule

// File: logic/min_select_tree.sv
/*
 * Pipelined minimum-select over the matching cores.
 * Nodes are kept heap style: node 1 is the root, leaves sit at num_core and up.
 * Each internal node is one register, so the result lands tree_levels cycles
 * after match, with its event tag delayed alongside.
 */
`timescale 1ns/1ps

module min_select_tree (
   input  logic                    clk,
   input  logic                    reset,
   input  monitor_pkg::op_kind_t   stage_op,
   input  monitor_pkg::core_id_t   stage_core,
   input  monitor_pkg::core_mask_t match,
   input  monitor_pkg::time_t      entry_time [monitor_pkg::num_core],
   output monitor_pkg::op_kind_t   res_op,
   output monitor_pkg::core_id_t   res_core,
   output monitor_pkg::core_id_t   sel_core,
   output logic                    sel_vld
);
   import monitor_pkg::*;

   // registered internal nodes
   time_t      node_time [1:num_core-1];
   core_id_t   node_idx  [1:num_core-1];
   logic [num_core-1:1] node_vld;

   // internal nodes plus leaves in one view
   time_t      all_time [1:2*num_core-1];
   core_id_t   all_idx  [1:2*num_core-1];
   logic [2*num_core-1:1] all_vld;
   logic [num_core-1:1]   take_left;

   // tag delay line
   op_kind_t   op_pipe   [tree_levels];
   core_id_t   core_pipe [tree_levels];

   always_comb begin
      for (int k = 1; k < num_core; k++) begin
         all_time[k] = node_time[k];
         all_idx[k] = node_idx[k];
         all_vld[k] = node_vld[k];
      end
      // leaves straight from the match stage
      for (int c = 0; c < num_core; c++) begin
         all_time[num_core + c] = entry_time[c];
         all_idx[num_core + c] = core_id_t'(c);
         all_vld[num_core + c] = match[c];
      end
      // left child holds the lower indices, so ties go left
      for (int k = 1; k < num_core; k++) begin
         take_left[k] = all_vld[2*k] &&
                        (!all_vld[2*k+1] || (all_time[2*k] <= all_time[2*k+1]));
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         node_vld <= '0;
      else
         for (int k = 1; k < num_core; k++)
            node_vld[k] <= all_vld[2*k] | all_vld[2*k+1];
   end

   always_ff @(posedge clk) begin
      for (int k = 1; k < num_core; k++) begin
         node_time[k] <= take_left[k] ? all_time[2*k] : all_time[2*k+1];
         node_idx[k] <= take_left[k] ? all_idx[2*k] : all_idx[2*k+1];
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < tree_levels; i++)
            op_pipe[i] <= op_none;
      end else begin
         op_pipe[0] <= stage_op;
         for (int i = 1; i < tree_levels; i++)
            op_pipe[i] <= op_pipe[i-1];
      end
   end

   always_ff @(posedge clk) begin
      core_pipe[0] <= stage_core;
      for (int i = 1; i < tree_levels; i++)
         core_pipe[i] <= core_pipe[i-1];
   end

   assign res_op = op_pipe[tree_levels-1];
   assign res_core = core_pipe[tree_levels-1];
   // root of the tree
   assign sel_core = node_idx[1];
   assign sel_vld = node_vld[1];

endmodule

// File: logic/stall_control.sv
/*
 * Stall register, one bit per core.
 * A send stalls its core on the sampling edge; tree results release
 * the origin (send, no match) or the selected waiter (return, match).
 */
`timescale 1ns/1ps

module stall_control (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    sent_vld,
   input  monitor_pkg::core_id_t   core_id,
   input  monitor_pkg::op_kind_t   res_op,
   input  monitor_pkg::core_id_t   res_core,
   input  monitor_pkg::core_id_t   sel_core,
   input  logic                    sel_vld,
   output monitor_pkg::core_mask_t stall
);
   import monitor_pkg::*;

   core_mask_t set_mask;
   core_mask_t rel_mask;

   // immediate stall of the destination core
   assign set_mask = sent_vld ? (core_mask_t'(1) << core_id) : '0;

   always_comb begin
      rel_mask = '0;
      case (res_op)
         op_send: begin
            // nobody else on this LP
            if (!sel_vld)
               rel_mask = core_mask_t'(1) << res_core;
         end
         op_recv: begin
            // earliest waiter on the returned LP
            if (sel_vld)
               rel_mask = core_mask_t'(1) << sel_core;
         end
         default: begin
            rel_mask = '0;
         end
      endcase
   end

   // release beats set on the same core
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         stall <= '0;
      else
         stall <= (stall | set_mask) & ~rel_mask;
   end

endmodule

// File: logic/lp_conflict_monitor.sv
/*
 * PDES core monitor top level.
 * Watches scheduler sends and core returns and drives one stall line
 * per core so that no two active cores work on the same LP.
 */
`timescale 1ns/1ps

module lp_conflict_monitor (
   input  logic                    clk,
   input  logic                    reset,
   input  monitor_pkg::msg_t       msg,
   input  logic                    sent_vld,
   input  logic                    rcv_vld,
   input  monitor_pkg::core_id_t   core_id,
   input  monitor_pkg::core_mask_t active,
   output monitor_pkg::core_mask_t stall
);
   import monitor_pkg::*;

   // table to tree
   op_kind_t   stage_op;
   core_id_t   stage_core;
   core_mask_t match;
   time_t      entry_time [num_core];

   // tree to stall register
   op_kind_t   res_op;
   core_id_t   res_core;
   core_id_t   sel_core;
   logic       sel_vld;

   core_table core_table_inst (
      .clk        (clk),
      .reset      (reset),
      .msg        (msg),
      .sent_vld   (sent_vld),
      .rcv_vld    (rcv_vld),
      .core_id    (core_id),
      .active     (active),
      .stage_op   (stage_op),
      .stage_core (stage_core),
      .match      (match),
      .entry_time (entry_time)
   );

   min_select_tree min_select_tree_inst (
      .clk        (clk),
      .reset      (reset),
      .stage_op   (stage_op),
      .stage_core (stage_core),
      .match      (match),
      .entry_time (entry_time),
      .res_op     (res_op),
      .res_core   (res_core),
      .sel_core   (sel_core),
      .sel_vld    (sel_vld)
   );

   // set path taken straight from the inputs
   stall_control stall_control_inst (
      .clk      (clk),
      .reset    (reset),
      .sent_vld (sent_vld),
      .core_id  (core_id),
      .res_op   (res_op),
      .res_core (res_core),
      .sel_core (sel_core),
      .sel_vld  (sel_vld),
      .stall    (stall)
   );

endmodule

// File: sim/lp_conflict_monitor_properties.sv
/*
 * Concurrent checks on the monitor's ports and tree result, bound into
 * the top level. fail_count is read by the testbench at the end of the run.
 */
`timescale 1ns/1ps

module lp_conflict_monitor_properties (
   input logic                    clk,
   input logic                    reset,
   input logic                    sent_vld,
   input logic                    rcv_vld,
   input monitor_pkg::core_id_t   core_id,
   input monitor_pkg::op_kind_t   res_op,
   input monitor_pkg::core_id_t   res_core,
   input monitor_pkg::core_id_t   sel_core,
   input logic                    sel_vld,
   input monitor_pkg::core_mask_t stall
);
   import monitor_pkg::*;

   int   fail_count = 0;
   logic rel_same;

   // tree result that releases the core being sent to on this edge
   assign rel_same = ((res_op == op_send) && !sel_vld && (res_core == core_id))
                     || ((res_op == op_recv) && sel_vld && (sel_core == core_id));

   stall_clear_in_reset: assert property (@(posedge clk) reset |-> (stall == '0))
      else begin
         $error("stall not clear while reset is high");
         fail_count++;
      end

   // set lands one edge after the send unless released on that edge
   send_sets_stall: assert property (@(posedge clk) disable iff (reset)
      (sent_vld && !rel_same) |=> stall[$past(core_id)])
      else begin
         $error("sent core not stalled one cycle after the send");
         fail_count++;
      end

   // input assumption
   no_send_and_return: assert property (@(posedge clk) disable iff (reset)
      !(sent_vld && rcv_vld))
      else begin
         $error("send and return valid in the same cycle");
         fail_count++;
      end

endmodule

bind lp_conflict_monitor lp_conflict_monitor_properties props_inst (.*);

// File: sim/lp_conflict_monitor_tb.sv
/*
 * Testbench for the PDES core monitor. Replays sim/monitor_vectors.txt,
 * one event per line, and checks the stall mask once the line's idle
 * cycles have passed. Build with the project file list.
 */
`timescale 1ns/1ps

module lp_conflict_monitor_tb;
   import monitor_pkg::*;

   // text field of a vector line
   typedef logic [8*24-1:0] label_t;

   logic       clk = 1'b0;
   logic       reset = 1'b1;
   msg_t       msg;
   logic       sent_vld;
   logic       rcv_vld;
   core_id_t   core_id;
   core_mask_t active;
   core_mask_t stall;

   int seed = 63;
   int checks = 0;
   int mismatches = 0;
   int other_errors = 0;

   lp_conflict_monitor lp_conflict_monitor_inst (.*);

   // 20 ns period
   always #10 clk = ~clk;

   // power-on reset held for 16 cycles
   initial begin
      repeat (16) @(negedge clk);
      reset = 1'b0;
   end

   task automatic compare_stall(input label_t name, input core_mask_t expected,
                                input core_mask_t actual);
      checks++;
      if (actual !== expected) begin
         mismatches++;
         $display("[FAIL] %0s: expected stall %b, actual %b", name, expected, actual);
      end
   endtask

   initial begin : replay
      string      line;
      string      tval;
      label_t     name;
      label_t     op;
      label_t     tstr;
      int         fd;
      int         core;
      int         lp;
      int         end_flag;
      int         idle;
      int         fields;
      int         waited;
      logic       done;
      time_t      stamp;
      core_mask_t act;
      core_mask_t expd;

      msg = '0;
      sent_vld = 1'b0;
      rcv_vld = 1'b0;
      core_id = '0;
      active = '0;
      fd = 0;
      waited = 0;
      // open retried for a few cycles
      while (fd == 0 && waited < 8) begin
         fd = $fopen("sim/monitor_vectors.txt", "r");
         waited++;
         if (fd == 0)
            @(negedge clk);
      end
      if (fd == 0) begin
         $display("vector file sim/monitor_vectors.txt could not be opened");
         other_errors++;
      end else begin
         waited = 0;
         // reset is sampled on the rising edge, away from where it changes
         while (reset && waited < 40) begin
            @(posedge clk);
            waited++;
         end
         if (reset) begin
            $display("reset still high after 40 cycles");
            other_errors++;
         end
         @(negedge clk);
         done = reset;
         while (!done) begin
            if ($fgets(line, fd) == 0) begin
               done = 1'b1;
            end else if (line.len() > 1 && line[0] != "#") begin
               fields = $sscanf(line, "%s %s %d %d %s %d %b %b %d", name, op, core,
                                lp, tstr, end_flag, act, expd, idle);
               if (fields != 9) begin
                  $display("vector line could not be parsed: %s", line);
                  other_errors++;
               end else begin
                  tval = string'(tstr);
                  if (tval == "rnd")
                     stamp = time_t'($random(seed));
                  else
                     stamp = time_t'(tval.atohex());
                  // message word from its fields
                  msg = '0;
                  msg[lp_lsb +: lp_id_w] = lp_id_t'(lp);
                  msg[time_lsb +: time_w] = stamp;
                  msg[end_bit] = end_flag[0];
                  core_id = core_id_t'(core);
                  active = act;
                  if (op == label_t'("send")) begin
                     sent_vld = 1'b1;
                  end else if (op == label_t'("recv")) begin
                     rcv_vld = 1'b1;
                  end else if (op == label_t'("reset")) begin
                     reset = 1'b1;
                     repeat (2) @(negedge clk);
                     reset = 1'b0;
                  end else begin
                     $display("unknown op %0s in line %0s", op, name);
                     other_errors++;
                  end
                  // valid for one cycle before the idle count
                  @(negedge clk);
                  sent_vld = 1'b0;
                  rcv_vld = 1'b0;
                  repeat (idle) @(negedge clk);
                  // short idle means the next event follows while this one is in flight
                  if (idle >= release_latency)
                     compare_stall(name, expd, stall);
               end
            end
         end
         $fclose(fd);
      end
      $display("checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
               checks, mismatches, other_errors,
               lp_conflict_monitor_inst.props_inst.fail_count);
      if (mismatches == 0 && other_errors == 0 &&
          lp_conflict_monitor_inst.props_inst.fail_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// File: lp_conflict_monitor.f
logic/monitor_pkg.sv
logic/core_table.sv
logic/min_select_tree.sv
logic/stall_control.sv
logic/lp_conflict_monitor.sv
sim/lp_conflict_monitor_properties.sv
sim/lp_conflict_monitor_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lp_conflict_monitor_tb
FILELIST  ?= lp_conflict_monitor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/monitor_vectors.txt
# name op core lp time end active expected idle
# time is hex or rnd for a random stamp, masks binary, other fields decimal
lone_send        send  0 3 000a 0 1111 0000 5
conflict_send    send  1 3 0014 0 1111 0010 5
second_waiter    send  2 3 000f 0 1111 0110 5
recv_earliest    recv  0 0 0000 1 1111 0010 5
third_waiter     send  3 3 0014 0 1111 1010 5
recv_tie         recv  0 0 0000 1 1011 1000 5
recv_no_end      recv  0 0 0000 0 1001 1000 5
lone_send_c2     send  2 5 0030 0 1111 1000 5
recv_no_match    recv  2 0 0000 1 1111 1000 5
mid_reset        reset 0 0 0000 0 1111 0000 5
b2b_core0        send  0 1 rnd  0 1111 0000 0
b2b_core1        send  1 2 rnd  0 1111 0000 0
b2b_core2        send  2 4 rnd  0 1111 0000 0
b2b_core3        send  3 6 rnd  0 1111 0000 5
